/* Makefile */
TOP = tb_branch_predictor

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f sources.f -o sim_$(TOP)
	out=$$(./obj_dir/sim_$(TOP)); echo "$$out"; \
		echo "$$out" | grep -qx "Test completed successfully"

clean:
	rm -rf obj_dir

/* bench/tb_branch_predictor.sv */
`timescale 1ns/1ps

module tb_branch_predictor;

    // Row operations of the stimulus table
    localparam int OP_LOOKUP = 0;
    localparam int OP_PEEK   = 1;
    localparam int OP_UPDATE = 2;
    localparam int OP_FLUSH  = 3;
    localparam int OP_WAIT   = 4;

    logic                  clk_i;
    logic                  rst_n_i;
    logic                  flush_i;
    logic                  lookup_valid_i;
    bpu_pkg::data_word_t   lookup_pc_i;
    bpu_pkg::branch_kind_t upd_kind_i;
    bpu_pkg::data_word_t   upd_pc_i;
    bpu_pkg::data_word_t   upd_target_i;
    logic                  upd_taken_i;
    logic                  ready_o;
    logic                  hit_o;
    logic                  predict_o;
    bpu_pkg::data_word_t   target_o;

    // Stimulus table, one entry per row in each queue
    string                 row_name[$];
    int                    row_op[$];
    bpu_pkg::data_word_t   row_pc[$];
    bpu_pkg::data_word_t   row_target[$];
    bpu_pkg::branch_kind_t row_kind[$];
    logic                  row_taken[$];
    logic                  row_exp_hit[$];
    logic                  row_exp_pred[$];
    int                    row_count = 0;
    int                    error_count = 0;
    int                    check_count = 0;

    branch_predictor i_dut (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .lookup_valid_i (lookup_valid_i),
        .lookup_pc_i    (lookup_pc_i),
        .upd_kind_i     (upd_kind_i),
        .upd_pc_i       (upd_pc_i),
        .upd_target_i   (upd_target_i),
        .upd_taken_i    (upd_taken_i),
        .ready_o        (ready_o),
        .hit_o          (hit_o),
        .predict_o      (predict_o),
        .target_o       (target_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        check_count++;
        if (exp !== act) begin
            error_count++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // For a lookup row the target column holds the expected target
    task automatic add_row(input string name, input int op, input bpu_pkg::data_word_t pc,
                           input bpu_pkg::data_word_t target,
                           input bpu_pkg::branch_kind_t kind, input logic taken,
                           input logic exp_hit, input logic exp_pred);
        row_name.push_back(name);
        row_op.push_back(op);
        row_pc.push_back(pc);
        row_target.push_back(target);
        row_kind.push_back(kind);
        row_taken.push_back(taken);
        row_exp_hit.push_back(exp_hit);
        row_exp_pred.push_back(exp_pred);
    endtask

    // Two-bit saturating direction counter, used to derive expected guesses
    function automatic logic [1:0] counter_step(input logic [1:0] ctr, input logic taken);
        if (taken) begin
            return (ctr == 2'b11) ? ctr : ctr + 2'b01;
        end
        return (ctr == 2'b00) ? ctr : ctr - 2'b01;
    endfunction

    // ------------------------------------------------------------------------
    // Watchdog sized from the table length and two full clearing sweeps
    // ------------------------------------------------------------------------

    initial begin
        wait (row_count > 0);
        repeat (row_count * 4 + 2 * bpu_pkg::BTB_ENTRIES + 8) @(posedge clk_i);
        $display("Timeout: the unit never finished the test sequence");
        $display("Test failed");
        $finish;
    end

    initial begin
        bpu_pkg::data_word_t pc_j;
        bpu_pkg::data_word_t pc_c;
        bpu_pkg::data_word_t pc_f;
        bpu_pkg::data_word_t pc_a;
        bpu_pkg::data_word_t rnd;
        logic [1:0]          ctr;

        rst_n_i        = 1'b0;
        flush_i        = 1'b0;
        lookup_valid_i = 1'b0;
        lookup_pc_i    = '0;
        upd_kind_i     = bpu_pkg::BR_NONE;
        upd_pc_i       = '0;
        upd_target_i   = '0;
        upd_taken_i    = 1'b0;
        rnd            = $urandom(39);

        // Alias of the jump pc with the same index and other upper bits
        pc_j = 32'h0000_1024;
        pc_c = 32'h0000_2048;
        pc_f = 32'h0000_300c;
        rnd  = $urandom();
        pc_a = {rnd[31:bpu_pkg::IDX_BITS+1], pc_j[bpu_pkg::IDX_BITS:0]};
        if (pc_a[31:bpu_pkg::IDX_BITS+1] == pc_j[31:bpu_pkg::IDX_BITS+1]) begin
            pc_a[31] = ~pc_a[31];
        end

        add_row("clear_done", OP_WAIT, pc_j, '0, bpu_pkg::BR_NONE, 0, 0, 0);
        add_row("cold_miss_j", OP_LOOKUP, pc_j, '0, bpu_pkg::BR_NONE, 0, 0, 0);
        add_row("cold_miss_c", OP_LOOKUP, pc_c, '0, bpu_pkg::BR_NONE, 0, 0, 0);
        add_row("jump_write", OP_UPDATE, pc_j, 32'h0000_8000, bpu_pkg::BR_JUMP, 1, 0, 0);
        add_row("jump_hit", OP_LOOKUP, pc_j, 32'h0000_8000, bpu_pkg::BR_NONE, 0, 1, 1);
        // Counters start weakly not taken, so one taken step flips the guess
        ctr = counter_step(bpu_pkg::CTR_WEAK_NT, 1'b1);
        add_row("cond_taken", OP_UPDATE, pc_c, 32'h0000_2100, bpu_pkg::BR_COND, 1, 0, 0);
        add_row("cond_hit_t", OP_LOOKUP, pc_c, 32'h0000_2100, bpu_pkg::BR_NONE, 0, 1, ctr[1]);
        ctr = counter_step(counter_step(ctr, 1'b0), 1'b0);
        add_row("cond_nt_1", OP_UPDATE, pc_c, 32'h0000_2100, bpu_pkg::BR_COND, 0, 0, 0);
        add_row("cond_nt_2", OP_UPDATE, pc_c, 32'h0000_2100, bpu_pkg::BR_COND, 0, 0, 0);
        add_row("cond_hit_nt", OP_LOOKUP, pc_c, 32'h0000_2100, bpu_pkg::BR_NONE, 0, 1, ctr[1]);
        add_row("fresh_nt", OP_UPDATE, pc_f, 32'h0000_3300, bpu_pkg::BR_COND, 0, 0, 0);
        add_row("fresh_miss", OP_LOOKUP, pc_f, '0, bpu_pkg::BR_NONE, 0, 0, 0);
        add_row("alias_miss", OP_LOOKUP, pc_a, '0, bpu_pkg::BR_NONE, 0, 0, 0);
        add_row("alias_write", OP_UPDATE, pc_a, 32'h0000_4400, bpu_pkg::BR_JUMP, 1, 0, 0);
        add_row("alias_hit", OP_LOOKUP, pc_a, 32'h0000_4400, bpu_pkg::BR_NONE, 0, 1, 1);
        add_row("alias_evict", OP_LOOKUP, pc_j, '0, bpu_pkg::BR_NONE, 0, 0, 0);
        add_row("invalid_look", OP_PEEK, pc_a, '0, bpu_pkg::BR_NONE, 0, 0, 0);
        add_row("flush", OP_FLUSH, '0, '0, bpu_pkg::BR_NONE, 0, 0, 0);
        add_row("flush_done", OP_WAIT, pc_a, '0, bpu_pkg::BR_NONE, 0, 0, 0);
        add_row("flushed_a", OP_LOOKUP, pc_a, '0, bpu_pkg::BR_NONE, 0, 0, 0);
        add_row("flushed_c", OP_LOOKUP, pc_c, '0, bpu_pkg::BR_NONE, 0, 0, 0);
        row_count = row_name.size();

        repeat (8) @(negedge clk_i);
        check_value("reset_ready", 32'd0, 32'(ready_o));
        check_value("reset_hit", 32'd0, 32'(hit_o));
        rst_n_i = 1'b1;

        // Back-to-back lookup rows keep one lookup in flight every cycle
        for (int i = 0; i < row_count; i++) begin
            case (row_op[i])
                OP_LOOKUP, OP_PEEK: begin
                    lookup_valid_i = (row_op[i] == OP_LOOKUP);
                    lookup_pc_i    = row_pc[i];
                    @(negedge clk_i);
                    lookup_valid_i = 1'b0;
                    check_value({row_name[i], " hit"}, 32'(row_exp_hit[i]), 32'(hit_o));
                    check_value({row_name[i], " predict"}, 32'(row_exp_pred[i]),
                                32'(predict_o));
                    if (row_exp_hit[i]) begin
                        check_value({row_name[i], " target"}, row_target[i], target_o);
                    end
                end
                OP_UPDATE: begin
                    upd_kind_i   = row_kind[i];
                    upd_pc_i     = row_pc[i];
                    upd_target_i = row_target[i];
                    upd_taken_i  = row_taken[i];
                    @(negedge clk_i);
                    upd_kind_i   = bpu_pkg::BR_NONE;
                end
                OP_FLUSH: begin
                    flush_i = 1'b1;
                    @(negedge clk_i);
                    flush_i = 1'b0;
                    check_value({row_name[i], " ready"}, 32'd0, 32'(ready_o));
                end
                default: begin
                    // Lookups offered while clearing must never hit
                    lookup_valid_i = 1'b1;
                    lookup_pc_i    = row_pc[i];
                    while (!ready_o) begin
                        check_value({row_name[i], " hit"}, 32'd0, 32'(hit_o));
                        @(negedge clk_i);
                    end
                    lookup_valid_i = 1'b0;
                end
            endcase
        end

        @(negedge clk_i);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : tb_branch_predictor

/* rtl/bpu_clear_fsm.sv */
`timescale 1ns/1ps

module bpu_clear_fsm (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic flush_i,
    input  logic sweep_last_i,
    output logic sweep_en_o,
    output logic clearing_o,
    output logic ready_o
);

    bpu_pkg::bpu_state_t state_q, state_d;

    // A flush wins over everything and restarts the sweep from index zero
    // The sweep leaves clearing only when the last index has been written
    always_comb begin
        state_d = state_q;
        if (flush_i) begin
            state_d = bpu_pkg::BPU_CLEAR;
        end else if (state_q == bpu_pkg::BPU_CLEAR && sweep_last_i) begin
            state_d = bpu_pkg::BPU_READY;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= bpu_pkg::BPU_CLEAR;
        end else begin
            state_q <= state_d;
        end
    end

    // Dropping the enable during a flush sends the sweeper back to zero
    assign sweep_en_o = (state_q == bpu_pkg::BPU_CLEAR) && !flush_i;
    assign clearing_o = (state_q == bpu_pkg::BPU_CLEAR);
    assign ready_o    = (state_q == bpu_pkg::BPU_READY);

    // The tables must never see a lookup or update while being swept
    a_ready_not_clearing : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !(ready_o && clearing_o)
    );

endmodule : bpu_clear_fsm

/* rtl/bpu_index_sweeper.sv */
`timescale 1ns/1ps

module bpu_index_sweeper (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         en_i,
    output logic [bpu_pkg::IDX_BITS-1:0] idx_o,
    output logic                         last_o
);

    logic [bpu_pkg::IDX_BITS-1:0] idx_q;

    // Counts up while enabled and falls back to zero as soon as it is not
    // The table size is a power of two, so the counter wraps by itself
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            idx_q <= '0;
        end else if (!en_i) begin
            idx_q <= '0;
        end else begin
            idx_q <= idx_q + 1'b1;
        end
    end

    assign idx_o = idx_q;

    // All ones marks the final table entry of the sweep
    assign last_o = en_i && (&idx_q);

    // Any pause in the sweep must leave the counter parked at index zero
    a_idle_at_zero : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !en_i |=> (idx_o == '0)
    );

endmodule : bpu_index_sweeper

/* rtl/bpu_pkg.sv */
package bpu_pkg;

    // ------------------------------------------------------------------------
    // Basic data types and table geometry
    // ------------------------------------------------------------------------

    // One machine word holds a program counter or a branch target
    typedef logic [31:0] data_word_t;

    // Both tables have the same number of entries and share one index
    localparam int BTB_ENTRIES = 64;

    // Index width, taken from program counter bits IDX_BITS down to 1
    localparam int IDX_BITS = $clog2(BTB_ENTRIES);

    // Tag width covers every program counter bit above the index
    localparam int TAG_BITS = 32 - IDX_BITS - 1;

    // ------------------------------------------------------------------------
    // Encodings
    // ------------------------------------------------------------------------

    // Kind of a resolved instruction, used as the update opcode
    typedef enum logic [1:0] {
        BR_NONE = 2'b00,
        BR_COND = 2'b01,
        BR_JUMP = 2'b10
    } branch_kind_t;

    // Controller states of the clearing sequence
    typedef enum logic {
        BPU_CLEAR = 1'b0,
        BPU_READY = 1'b1
    } bpu_state_t;

    // Weakly not taken, the starting value of every direction counter
    localparam logic [1:0] CTR_WEAK_NT = 2'b01;

endpackage : bpu_pkg

/* rtl/branch_history_table.sv */
`timescale 1ns/1ps

module branch_history_table (
    input  logic                         clk_i,
    input  logic                         clearing_i,
    input  logic [bpu_pkg::IDX_BITS-1:0] sweep_idx_i,
    input  bpu_pkg::data_word_t          lookup_pc_i,
    input  bpu_pkg::branch_kind_t        upd_kind_i,
    input  bpu_pkg::data_word_t          upd_pc_i,
    input  logic                         upd_taken_i,
    output logic                         taken_o
);

    // ------------------------------------------------------------------------
    // Counter storage
    // ------------------------------------------------------------------------

    // Untagged, so branches with the same index share one counter
    logic [1:0] ctr_mem [bpu_pkg::BTB_ENTRIES];

    logic [bpu_pkg::IDX_BITS-1:0] rd_idx;
    logic [bpu_pkg::IDX_BITS-1:0] upd_idx;
    logic [1:0]                   ctr_cur;
    logic [1:0]                   ctr_nxt;

    assign rd_idx  = lookup_pc_i[bpu_pkg::IDX_BITS:1];
    assign upd_idx = upd_pc_i[bpu_pkg::IDX_BITS:1];

    // Current value of the counter being trained
    assign ctr_cur = ctr_mem[upd_idx];

    // Saturating step, strongly taken is 3 and strongly not taken is 0
    always_comb begin
        ctr_nxt = ctr_cur;
        if (upd_taken_i) begin
            if (ctr_cur != 2'b11) begin
                ctr_nxt = ctr_cur + 2'b01;
            end
        end else begin
            if (ctr_cur != 2'b00) begin
                ctr_nxt = ctr_cur - 2'b01;
            end
        end
    end

    // Only conditional branches train the direction counters
    always_ff @(posedge clk_i) begin
        if (clearing_i) begin
            ctr_mem[sweep_idx_i] <= bpu_pkg::CTR_WEAK_NT;
        end else if (upd_kind_i == bpu_pkg::BR_COND) begin
            ctr_mem[upd_idx] <= ctr_nxt;
        end
    end

    // ------------------------------------------------------------------------
    // Registered read
    // ------------------------------------------------------------------------

    logic [1:0] rd_ctr_q;

    always_ff @(posedge clk_i) begin
        rd_ctr_q <= ctr_mem[rd_idx];
    end

    // The upper counter bit is the taken guess
    assign taken_o = rd_ctr_q[1];

endmodule : branch_history_table

/* rtl/branch_predictor.sv */
`timescale 1ns/1ps

module branch_predictor (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  flush_i,
    input  logic                  lookup_valid_i,
    input  bpu_pkg::data_word_t   lookup_pc_i,
    input  bpu_pkg::branch_kind_t upd_kind_i,
    input  bpu_pkg::data_word_t   upd_pc_i,
    input  bpu_pkg::data_word_t   upd_target_i,
    input  logic                  upd_taken_i,
    output logic                  ready_o,
    output logic                  hit_o,
    output logic                  predict_o,
    output bpu_pkg::data_word_t   target_o
);

    logic                         sweep_en;
    logic                         sweep_last;
    logic [bpu_pkg::IDX_BITS-1:0] sweep_idx;
    logic                         clearing;
    logic                         lookup_valid_g;
    bpu_pkg::branch_kind_t        upd_kind_g;
    logic                         btb_is_jump;
    logic                         bht_taken;

    // ------------------------------------------------------------------------
    // Clearing control
    // ------------------------------------------------------------------------

    bpu_clear_fsm i_fsm (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .sweep_last_i (sweep_last),
        .sweep_en_o   (sweep_en),
        .clearing_o   (clearing),
        .ready_o      (ready_o)
    );

    bpu_index_sweeper i_sweep (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .en_i    (sweep_en),
        .idx_o   (sweep_idx),
        .last_o  (sweep_last)
    );

    // ------------------------------------------------------------------------
    // Tables
    // ------------------------------------------------------------------------

    // Requests are ignored until both tables hold their reset contents
    assign lookup_valid_g = lookup_valid_i && ready_o;
    assign upd_kind_g     = ready_o ? upd_kind_i : bpu_pkg::BR_NONE;

    branch_target_buffer i_btb (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .clearing_i     (clearing),
        .sweep_idx_i    (sweep_idx),
        .lookup_valid_i (lookup_valid_g),
        .lookup_pc_i    (lookup_pc_i),
        .upd_kind_i     (upd_kind_g),
        .upd_pc_i       (upd_pc_i),
        .upd_target_i   (upd_target_i),
        .upd_taken_i    (upd_taken_i),
        .hit_o          (hit_o),
        .is_jump_o      (btb_is_jump),
        .target_o       (target_o)
    );

    branch_history_table i_bht (
        .clk_i       (clk_i),
        .clearing_i  (clearing),
        .sweep_idx_i (sweep_idx),
        .lookup_pc_i (lookup_pc_i),
        .upd_kind_i  (upd_kind_g),
        .upd_pc_i    (upd_pc_i),
        .upd_taken_i (upd_taken_i),
        .taken_o     (bht_taken)
    );

    // Jumps are always taken, conditional branches follow their counter
    assign predict_o = hit_o && (btb_is_jump || bht_taken);

endmodule : branch_predictor

/* rtl/branch_target_buffer.sv */
`timescale 1ns/1ps

module branch_target_buffer (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         clearing_i,
    input  logic [bpu_pkg::IDX_BITS-1:0] sweep_idx_i,
    input  logic                         lookup_valid_i,
    input  bpu_pkg::data_word_t          lookup_pc_i,
    input  bpu_pkg::branch_kind_t        upd_kind_i,
    input  bpu_pkg::data_word_t          upd_pc_i,
    input  bpu_pkg::data_word_t          upd_target_i,
    input  logic                         upd_taken_i,
    output logic                         hit_o,
    output logic                         is_jump_o,
    output bpu_pkg::data_word_t          target_o
);

    // ------------------------------------------------------------------------
    // Entry storage
    // ------------------------------------------------------------------------

    // One entry of the direct-mapped buffer
    typedef struct packed {
        logic                         valid;
        logic [bpu_pkg::TAG_BITS-1:0] tag;
        logic                         is_jump;
        bpu_pkg::data_word_t          target;
    } btb_entry_t;

    btb_entry_t btb_mem [bpu_pkg::BTB_ENTRIES];

    logic [bpu_pkg::IDX_BITS-1:0] rd_idx;
    logic [bpu_pkg::IDX_BITS-1:0] upd_idx;
    logic                         upd_wr;

    // Bit 0 of the program counter never selects an entry
    assign rd_idx  = lookup_pc_i[bpu_pkg::IDX_BITS:1];
    assign upd_idx = upd_pc_i[bpu_pkg::IDX_BITS:1];

    // Jumps always allocate, conditional branches only when they were taken
    assign upd_wr = (upd_kind_i == bpu_pkg::BR_JUMP) ||
                    (upd_kind_i == bpu_pkg::BR_COND && upd_taken_i);

    // Single write port, the sweep has priority over updates
    always_ff @(posedge clk_i) begin
        if (clearing_i) begin
            btb_mem[sweep_idx_i] <= '0;
        end else if (upd_wr) begin
            btb_mem[upd_idx] <= '{
                valid:   1'b1,
                tag:     upd_pc_i[31:bpu_pkg::IDX_BITS+1],
                is_jump: (upd_kind_i == bpu_pkg::BR_JUMP),
                target:  upd_target_i
            };
        end
    end

    // ------------------------------------------------------------------------
    // Registered read and tag compare
    // ------------------------------------------------------------------------

    btb_entry_t                   rd_entry_q;
    logic [bpu_pkg::TAG_BITS-1:0] lookup_tag_q;
    logic                         lookup_valid_q;

    // A write on the same edge is not seen, the old entry is returned
    always_ff @(posedge clk_i) begin
        rd_entry_q   <= btb_mem[rd_idx];
        lookup_tag_q <= lookup_pc_i[31:bpu_pkg::IDX_BITS+1];
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            lookup_valid_q <= 1'b0;
        end else begin
            lookup_valid_q <= lookup_valid_i;
        end
    end

    assign hit_o     = lookup_valid_q && rd_entry_q.valid && (rd_entry_q.tag == lookup_tag_q);
    assign is_jump_o = rd_entry_q.is_jump;
    assign target_o  = rd_entry_q.target;

    // Updates are held off upstream for the whole sweep
    a_no_update_while_clearing : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        clearing_i |-> !upd_wr
    );

endmodule : branch_target_buffer

/* sources.f */
rtl/bpu_pkg.sv
rtl/bpu_clear_fsm.sv
rtl/bpu_index_sweeper.sv
rtl/branch_target_buffer.sv
rtl/branch_history_table.sv
rtl/branch_predictor.sv
bench/tb_branch_predictor.sv
